//--- axi_sram_macros.svh
//##########################################################################
// Bus width and address step macros for the AXI read bridge
// Include in any file that sizes an AXI or SRAM port
//##########################################################################
`ifndef AXI_SRAM_MACROS_SVH
`define AXI_SRAM_MACROS_SVH

`define AXI_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_ID_W   4
`define AXI_LEN_W  4
`define AXI_STRB_W (`AXI_DATA_W / 8)
// Byte offset bits below the bus word index
`define ADDR_LSB   $clog2(`AXI_STRB_W)

`endif

//--- axi_sram_pkg.sv
//##########################################################################
// Shared types of the AXI read bridge: burst and FSM enums, stored command
//##########################################################################
`default_nettype none
`include "axi_sram_macros.svh"

package axi_sram_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        RD_IDLE  = 2'b00,
        RD_ISSUE = 2'b01,
        RD_HOLD  = 2'b10
    } rd_state_e;

    // One AR command as held in the buffer
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        burst_e                 burst;
        logic [`AXI_LEN_W-1:0]  len;
        logic [`AXI_ID_W-1:0]   id;
    } rd_cmd_t;

endpackage

`default_nettype wire

//--- rd_cmd_if.sv
//##########################################################################
// Head read command hand-off from the AR buffer to the burst logic
// Producer owns the head, controller retires it, observers follow it
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

interface rd_cmd_if;
    import axi_sram_pkg::*;

    logic    head_valid;
    rd_cmd_t cmd;
    logic    load;          // First cycle of a new head
    logic    pop;           // Head retires at this edge

    modport producer (
        output head_valid,
        output cmd,
        output load,
        input  pop
    );

    modport controller (
        input  head_valid,
        output pop
    );

    modport observer (
        input head_valid,
        input cmd,
        input load,
        input pop
    );

endinterface

`default_nettype wire

//--- ar_cmd_buffer.sv
//##########################################################################
// Two-entry AR command buffer: head entry plus one spare
// Drives arready and presents the head command on rd_cmd_if
//##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_macros.svh"

module ar_cmd_buffer (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   arvalid,
    output logic                   arready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  axi_sram_pkg::burst_e   arburst,
    input  logic [`AXI_LEN_W-1:0]  arlen,
    input  logic [`AXI_ID_W-1:0]   arid,
    rd_cmd_if.producer             cmd_if
);
    import axi_sram_pkg::*;

    rd_cmd_t in_cmd;
    rd_cmd_t spare_cmd;
    logic    spare_valid;
    logic    accept;
    logic    to_head;
    logic    to_spare;
    logic    spare_to_head;

    assign in_cmd = '{addr: araddr, burst: arburst, len: arlen, id: arid};

    assign arready = !spare_valid;      // Spare only fills behind a head
    assign accept  = arvalid && arready;

    // Incoming command skips the spare when the head is free or retiring
    assign to_head       = accept && (!cmd_if.head_valid || cmd_if.pop);
    assign to_spare      = accept && cmd_if.head_valid && !cmd_if.pop;
    assign spare_to_head = cmd_if.pop && spare_valid;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            cmd_if.head_valid <= 1'b0;
            cmd_if.load       <= 1'b0;
            spare_valid       <= 1'b0;
        end
        else
        begin
            cmd_if.load <= to_head || spare_to_head;
            if (to_head || spare_to_head)
                cmd_if.head_valid <= 1'b1;
            else if (cmd_if.pop)
                cmd_if.head_valid <= 1'b0;
            if (to_spare)
                spare_valid <= 1'b1;
            else if (spare_to_head)
                spare_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (to_head)
            cmd_if.cmd <= in_cmd;
        else if (spare_to_head)
            cmd_if.cmd <= spare_cmd;    // Oldest waiting command moves up
    end

    always_ff @(posedge aclk)
    begin
        if (to_spare)
            spare_cmd <= in_cmd;
    end

    // A retire always targets a present head
    a_pop_has_head: assert property (
        @(posedge aclk) disable iff (!aresetn)
        cmd_if.pop |-> cmd_if.head_valid
    );

endmodule

`default_nettype wire

//--- rd_burst_fsm.sv
//##########################################################################
// Read burst FSM: issues one SRAM read per beat when the R stage is free
// and retires the head command on its last beat
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module rd_burst_fsm (
    input  logic          aclk,
    input  logic          aresetn,
    input  logic          rready,
    input  logic          rvalid,
    input  logic          last_beat,
    rd_cmd_if.controller  cmd_if,
    output logic          beat_en,
    output logic          ram_ren
);
    import axi_sram_pkg::*;

    rd_state_e state;
    rd_state_e state_nxt;
    logic      out_free;

    assign out_free = !rvalid || rready;   // R register can take a new beat

    assign beat_en    = (state != RD_IDLE) && cmd_if.head_valid && out_free;
    assign ram_ren    = beat_en;
    assign cmd_if.pop = beat_en && last_beat;

    always_comb
    begin
        state_nxt = state;
        case (state)
            RD_IDLE:
            begin
                if (cmd_if.head_valid)
                    state_nxt = RD_ISSUE;
            end
            RD_ISSUE:
            begin
                // Stay here across a pop if the next head is already in place
                if (!cmd_if.head_valid)
                    state_nxt = RD_IDLE;
                else if (rvalid && !rready)
                    state_nxt = RD_HOLD;
            end
            RD_HOLD:
            begin
                if (rready)
                    state_nxt = RD_ISSUE;
            end
            default:
            begin
                state_nxt = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= RD_IDLE;
        else
            state <= state_nxt;
    end

    // RD_HOLD only ever waits on a stalled R beat
    a_hold_on_beat: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (state == RD_HOLD) |-> rvalid
    );

endmodule

`default_nettype wire

//--- beat_counter.sv
//##########################################################################
// Counts issued beats of the head burst and flags the last one
//##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_macros.svh"

module beat_counter (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        beat_en,
    rd_cmd_if.observer  cmd_if,
    output logic        last_beat
);

    logic [`AXI_LEN_W-1:0] beat_cnt;

    // Restart at every retire so the next head begins at beat 0
    always_ff @(posedge aclk)
    begin
        if (!aresetn || cmd_if.pop)
            beat_cnt <= '0;
        else if (beat_en)
            beat_cnt <= beat_cnt + 1'b1;
    end

    assign last_beat = cmd_if.head_valid && (beat_cnt == cmd_if.cmd.len);

endmodule

`default_nettype wire

//--- burst_addr_gen.sv
//##########################################################################
// Beat address of the head burst with FIXED, INCR and WRAP stepping
// Drives the SRAM read address directly
//##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_macros.svh"

module burst_addr_gen (
    input  logic                   aclk,
    input  logic                   beat_en,
    input  logic                   last_beat,
    rd_cmd_if.observer             cmd_if,
    output logic [`AXI_ADDR_W-1:0] ram_raddr
);
    import axi_sram_pkg::*;

    logic [`AXI_ADDR_W-1:0] addr_q;
    logic [`AXI_ADDR_W-1:0] addr_cur;
    logic [`AXI_ADDR_W-1:0] addr_incr;
    logic [`AXI_ADDR_W-1:0] addr_wrap;
    logic [`AXI_ADDR_W-1:0] addr_next;
    logic [`AXI_LEN_W-1:0]  idx;
    logic [`AXI_LEN_W-1:0]  idx_inc;

    // A fresh head addresses the SRAM in its first cycle
    assign addr_cur  = cmd_if.load ? cmd_if.cmd.addr : addr_q;
    assign ram_raddr = addr_cur;

    assign idx     = addr_cur[`ADDR_LSB +: `AXI_LEN_W];   // Beat index bits
    assign idx_inc = idx + 1'b1;

    always_comb
    begin
        addr_incr = addr_cur;
        addr_incr[`AXI_ADDR_W-1:`ADDR_LSB] = addr_cur[`AXI_ADDR_W-1:`ADDR_LSB] + 1'b1;
    end

    // len ones select the bits that count, len zeros pin the block base
    always_comb
    begin
        addr_wrap = addr_cur;
        addr_wrap[`ADDR_LSB +: `AXI_LEN_W] = (idx & ~cmd_if.cmd.len)
                                           | (idx_inc & cmd_if.cmd.len);
    end

    always_comb
    begin
        case (cmd_if.cmd.burst)
            BURST_INCR: addr_next = addr_incr;
            BURST_WRAP: addr_next = addr_wrap;
            default:    addr_next = addr_cur;       // FIXED
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (beat_en && !last_beat)
            addr_q <= addr_next;
        else if (cmd_if.load)
            addr_q <= cmd_if.cmd.addr;
    end

    // WRAP needs a power-of-two beat count
    a_wrap_len: assert property (
        @(posedge aclk)
        cmd_if.load && (cmd_if.cmd.burst == BURST_WRAP)
            |-> cmd_if.cmd.len inside {4'd1, 4'd3, 4'd7, 4'd15}
    );

endmodule

`default_nettype wire

//--- r_channel_stage.sv
//##########################################################################
// R channel register: rvalid, rid and rlast follow each SRAM read by
// one cycle and hold while the master stalls
//##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_macros.svh"

module r_channel_stage (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 beat_en,
    input  logic                 last_beat,
    rd_cmd_if.observer           cmd_if,
    input  logic                 rready,
    output logic                 rvalid,
    output logic [`AXI_ID_W-1:0] rid,
    output logic                 rlast
);

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
        end
        else if (beat_en)
        begin
            rvalid <= 1'b1;         // New beat replaces an accepted one
            rlast  <= last_beat;
        end
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge aclk)
    begin
        if (beat_en)
            rid <= cmd_if.cmd.id;
    end

    // Stalled beat keeps its id and last flag until taken
    a_r_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rid) && $stable(rlast)
    );

endmodule

`default_nettype wire

//--- axi_sram_rd_top.sv
//##########################################################################
// Read half of the AXI to SRAM bridge: AR and R channels in, SRAM
// read port out, one-cycle SRAM read latency
//##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_macros.svh"

module axi_sram_rd_top (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic [1:0]             arburst,
    input  logic [`AXI_LEN_W-1:0]  arlen,
    input  logic [`AXI_ID_W-1:0]   arid,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [`AXI_ID_W-1:0]   rid,
    output logic [1:0]             rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`AXI_ADDR_W-1:0] ram_raddr,
    output logic                   ram_ren,
    input  logic [`AXI_DATA_W-1:0] ram_rdata
);
    import axi_sram_pkg::*;

    logic beat_en;
    logic last_beat;

    rd_cmd_if cmd_if ();

    assign rdata = ram_rdata;       // SRAM output holds between reads
    assign rresp = 2'b00;           // OKAY

    ar_cmd_buffer u_ar_cmd_buffer (
        .aclk    (aclk),
        .aresetn (aresetn),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arburst (burst_e'(arburst)),
        .arlen   (arlen),
        .arid    (arid),
        .cmd_if  (cmd_if.producer)
    );

    rd_burst_fsm u_rd_burst_fsm (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .rready    (rready),
        .rvalid    (rvalid),
        .last_beat (last_beat),
        .cmd_if    (cmd_if.controller),
        .beat_en   (beat_en),
        .ram_ren   (ram_ren)
    );

    beat_counter u_beat_counter (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .beat_en   (beat_en),
        .cmd_if    (cmd_if.observer),
        .last_beat (last_beat)
    );

    burst_addr_gen u_burst_addr_gen (
        .aclk      (aclk),
        .beat_en   (beat_en),
        .last_beat (last_beat),
        .cmd_if    (cmd_if.observer),
        .ram_raddr (ram_raddr)
    );

    r_channel_stage u_r_channel_stage (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .beat_en   (beat_en),
        .last_beat (last_beat),
        .cmd_if    (cmd_if.observer),
        .rready    (rready),
        .rvalid    (rvalid),
        .rid       (rid),
        .rlast     (rlast)
    );

endmodule

`default_nettype wire

//--- tb_axi_sram_rd.sv
//##########################################################################
// Testbench for the AXI read bridge: SRAM model, random AR commands and
// rready stalls, reference beat model with checks on every R beat
//##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "axi_sram_macros.svh"

module tb_axi_sram_rd;
    import axi_sram_pkg::*;

    localparam logic [31:0] SEED = 32'he923;
    localparam int NUM_CMDS       = 200;
    localparam int CYCLES_PER_CMD = 40;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * CYCLES_PER_CMD;
    localparam int DRIVE_DLY      = 2;
    localparam int WORD_W         = `AXI_ADDR_W - `ADDR_LSB;

    logic                   aclk;
    logic                   aresetn;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic [1:0]             arburst;
    logic [`AXI_LEN_W-1:0]  arlen;
    logic [`AXI_ID_W-1:0]   arid;
    logic                   arvalid;
    logic                   arready;
    logic [`AXI_DATA_W-1:0] rdata;
    logic [`AXI_ID_W-1:0]   rid;
    logic [1:0]             rresp;
    logic                   rlast;
    logic                   rvalid;
    logic                   rready;
    logic [`AXI_ADDR_W-1:0] ram_raddr;
    logic                   ram_ren;
    logic [`AXI_DATA_W-1:0] ram_rdata = '0;

    // Expected beats, read side and R side
    logic [`AXI_ADDR_W-1:0] issue_addr_q[$];
    logic                   issue_last_q[$];
    logic [`AXI_ADDR_W-1:0] beat_addr_q[$];
    logic [`AXI_ID_W-1:0]   beat_id_q[$];
    logic                   beat_last_q[$];

    int   errors = 0;
    int   cmds_accepted = 0;
    int   beats_checked = 0;
    int   stall_cycles = 0;
    int   full_cycles = 0;
    int   occupancy = 0;            // Commands held in the DUT buffer
    int   cycles = 0;
    logic mon_on = 1'b0;

    logic                   hold_pending = 1'b0;
    logic [`AXI_DATA_W-1:0] held_data;
    logic [`AXI_ID_W-1:0]   held_id;
    logic                   held_last;

    axi_sram_rd_top uut (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .araddr    (araddr),
        .arburst   (arburst),
        .arlen     (arlen),
        .arid      (arid),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rid       (rid),
        .rresp     (rresp),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready),
        .ram_raddr (ram_raddr),
        .ram_ren   (ram_ren),
        .ram_rdata (ram_rdata)
    );

    // Word index low, its inverse high
    function automatic logic [`AXI_DATA_W-1:0] word_data(input logic [`AXI_ADDR_W-1:0] addr);
        logic [31:0] widx;
        widx = 32'(addr[`AXI_ADDR_W-1:`ADDR_LSB]);
        return {~widx, widx};
    endfunction

    function automatic logic [`AXI_ADDR_W-1:0] next_beat_addr(
        input logic [`AXI_ADDR_W-1:0] addr,
        input logic [1:0]             burst,
        input logic [`AXI_LEN_W-1:0]  len
    );
        logic [WORD_W-1:0] word;
        logic [WORD_W-1:0] base;
        logic [WORD_W-1:0] nbeats;
        nbeats = WORD_W'(len) + 1'b1;
        word   = addr[`AXI_ADDR_W-1:`ADDR_LSB];
        if (burst == BURST_INCR)
            word = word + 1'b1;
        else if (burst == BURST_WRAP)
        begin
            base = word - (word % nbeats);      // Block aligned to len+1 words
            word = base + ((word - base + 1'b1) % nbeats);
        end
        return {word, addr[`ADDR_LSB-1:0]};
    endfunction

    // Reference model: one command into its len+1 expected beats
    task automatic expand_cmd(
        input logic [`AXI_ADDR_W-1:0] addr,
        input logic [1:0]             burst,
        input logic [`AXI_LEN_W-1:0]  len,
        input logic [`AXI_ID_W-1:0]   id
    );
        logic [`AXI_ADDR_W-1:0] a;
        a = addr;
        for (int b = 0; b <= int'(len); b++)
        begin
            issue_addr_q.push_back(a);
            issue_last_q.push_back(b == int'(len));
            beat_addr_q.push_back(a);
            beat_id_q.push_back(id);
            beat_last_q.push_back(b == int'(len));
            a = next_beat_addr(a, burst, len);
        end
    endtask

    task automatic send_cmd();
        int                    gap;
        logic                  taken;
        logic [1:0]            burst;
        logic [`AXI_LEN_W-1:0] len;
        gap = 0;
        if ($urandom % 4 == 0)
            gap = 1 + int'($urandom % 3);
        repeat (gap)
        begin
            @(posedge aclk);
            #DRIVE_DLY;
        end
        case ($urandom % 3)
            0:       burst = BURST_FIXED;
            1:       burst = BURST_INCR;
            default: burst = BURST_WRAP;
        endcase
        if (burst == BURST_WRAP)
            len = `AXI_LEN_W'((1 << (1 + $urandom % 4)) - 1);  // 1, 3, 7 or 15
        else
            len = `AXI_LEN_W'($urandom % 16);
        araddr  = $urandom;
        arburst = burst;
        arlen   = len;
        arid    = `AXI_ID_W'($urandom);
        arvalid = 1'b1;
        taken   = 1'b0;
        while (!taken)
        begin
            @(negedge aclk);
            taken = arready;
            @(posedge aclk);
            #DRIVE_DLY;
        end
        arvalid = 1'b0;
    endtask

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // SRAM with one-cycle read latency, output held between reads
    always @(posedge aclk)
    begin
        if (ram_ren)
            ram_rdata <= word_data(ram_raddr);
    end

    initial
    begin
        rready = 1'b0;
        forever
        begin
            @(posedge aclk);
            #DRIVE_DLY;
            rready = ($urandom % 100) >= 30;
        end
    end

    // Monitor at the falling edge, where every DUT output has settled
    always @(negedge aclk)
    begin
        logic [`AXI_ADDR_W-1:0] exp_addr;
        logic [`AXI_ID_W-1:0]   exp_id;
        logic                   exp_last;
        if (mon_on)
        begin
            assert (arready == (occupancy < 2))
            else
            begin
                errors++;
                $display("[FAIL] arready got %h expected %h", arready, occupancy < 2);
            end
            if (!arready)
                full_cycles++;
            if (hold_pending)
            begin
                stall_cycles++;
                assert (rvalid && rdata == held_data && rid == held_id && rlast == held_last)
                else
                begin
                    errors++;
                    $display("[FAIL] stalled beat rvalid %h rdata %h rid %h rlast %h",
                             rvalid, rdata, rid, rlast);
                    $display("[FAIL] stalled beat held rdata %h rid %h rlast %h",
                             held_data, held_id, held_last);
                end
            end
            hold_pending = rvalid && !rready;
            held_data    = rdata;
            held_id      = rid;
            held_last    = rlast;
            if (ram_ren)
            begin
                assert (!rvalid || rready)
                else
                begin
                    errors++;
                    $display("SRAM read issued while the R beat was stalled");
                end
                assert (issue_addr_q.size() != 0)
                else
                begin
                    errors++;
                    $display("SRAM read issued with no beat expected");
                end
                if (issue_addr_q.size() != 0)
                begin
                    exp_addr = issue_addr_q.pop_front();
                    exp_last = issue_last_q.pop_front();
                    assert (ram_raddr == exp_addr)
                    else
                    begin
                        errors++;
                        $display("[FAIL] ram_raddr got %h expected %h", ram_raddr, exp_addr);
                    end
                    if (exp_last)
                        occupancy--;        // Head retires at this edge
                end
            end
            if (rvalid && rready)
            begin
                assert (beat_addr_q.size() != 0)
                else
                begin
                    errors++;
                    $display("R beat returned with no beat expected");
                end
                if (beat_addr_q.size() != 0)
                begin
                    exp_addr = beat_addr_q.pop_front();
                    exp_id   = beat_id_q.pop_front();
                    exp_last = beat_last_q.pop_front();
                    beats_checked++;
                    assert (rdata == word_data(exp_addr))
                    else
                    begin
                        errors++;
                        $display("[FAIL] rdata got %h expected %h", rdata, word_data(exp_addr));
                    end
                    assert (rid == exp_id)
                    else
                    begin
                        errors++;
                        $display("[FAIL] rid got %h expected %h", rid, exp_id);
                    end
                    assert (rlast == exp_last)
                    else
                    begin
                        errors++;
                        $display("[FAIL] rlast got %h expected %h", rlast, exp_last);
                    end
                    assert (rresp == 2'b00)
                    else
                    begin
                        errors++;
                        $display("[FAIL] rresp got %h expected %h", rresp, 2'b00);
                    end
                end
            end
            if (arvalid && arready)
            begin
                expand_cmd(araddr, arburst, arlen, arid);
                occupancy++;
                cmds_accepted++;
            end
        end
    end

    initial
    begin
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d beats still outstanding",
                 cycles, beat_addr_q.size());
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        void'($urandom(SEED));
        aresetn = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        arburst = 2'b00;
        arlen   = '0;
        arid    = '0;
        repeat (2) @(posedge aclk);
        #DRIVE_DLY;
        aresetn = 1'b1;
        mon_on  = 1'b1;
        @(negedge aclk);
        assert (arready == 1'b1)
        else
        begin
            errors++;
            $display("[FAIL] arready got %h expected %h", arready, 1'b1);
        end
        assert (rvalid == 1'b0)
        else
        begin
            errors++;
            $display("[FAIL] rvalid got %h expected %h", rvalid, 1'b0);
        end
        @(posedge aclk);
        #DRIVE_DLY;
        for (int i = 0; i < NUM_CMDS; i++)
            send_cmd();
        while (beat_addr_q.size() != 0)
            @(posedge aclk);
        repeat (4) @(posedge aclk);
        assert (issue_addr_q.size() == 0 && occupancy == 0)
        else
        begin
            errors++;
            $display("SRAM reads or buffered commands left over after the last beat");
        end
        assert (full_cycles > 0)
        else
        begin
            errors++;
            $display("arready never dropped, the command buffer never filled");
        end
        $display("Commands %0d, beats %0d, stalled cycles %0d, full cycles %0d, errors %0d",
                 cmds_accepted, beats_checked, stall_cycles, full_cycles, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
axi_sram_pkg.sv
rd_cmd_if.sv
ar_cmd_buffer.sv
rd_burst_fsm.sv
beat_counter.sv
burst_addr_gen.sv
r_channel_stage.sv
axi_sram_rd_top.sv
tb_axi_sram_rd.sv

//--- run.sh
#!/bin/sh
# Build and run the AXI read bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_axi_sram_rd \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
exit 0
